//--- rtl/exe_pkg.sv
package exe_pkg;

    typedef logic [31:0] word_t;   // operands, results, addresses, write data
    typedef logic [3:0]  strb_t;   // one bit per byte lane
    typedef logic [1:0]  size_t;

    // access size codes on the memory side
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // nominal divider width, one quotient bit per cycle
    localparam int DIV_STEPS = 32;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_sll,
        op_srl,
        op_divu,
        op_remu,
        op_lw,
        op_lh,
        op_lb,
        op_sw,
        op_sh,
        op_sb
    } exe_op_t;

    typedef enum logic [1:0] {
        exc_none,
        exc_ovf,   // signed overflow on add
        exc_adel,  // misaligned load
        exc_ades   // misaligned store
    } exc_t;

    typedef enum logic [1:0] {
        st_empty,
        st_alu,
        st_div,
        st_mem
    } ctrl_state_t;

endpackage

//--- rtl/exe_div_if.sv
`timescale 1ns/1ns

interface div_if;
    import exe_pkg::*;

    logic  start;      // one-cycle pulse from the controller
    word_t dividend;
    word_t divisor;
    logic  busy;
    logic  done;       // one-cycle pulse, results valid from here
    word_t quotient;
    word_t remainder;

    modport ctrl (
        output start, dividend, divisor,
        input  busy, done, quotient, remainder
    );

    modport div (
        input  start, dividend, divisor,
        output busy, done, quotient, remainder
    );

endinterface

//--- rtl/div_iter_count.sv
`timescale 1ns/1ns

module div_iter_count #(
    parameter int STEPS = exe_pkg::DIV_STEPS
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic busy,
    output logic done
);
    localparam int CW = $clog2(STEPS + 1);

    logic [CW-1:0] cnt;   // steps still to run after the current one

    assign busy = (cnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= (start && (STEPS == 1)) || (busy && (cnt == CW'(1)));
            if (start)
                cnt <= CW'(STEPS - 1);   // first step runs on the start edge
            else if (busy)
                cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- rtl/div_unit.sv
`timescale 1ns/1ns

module div_unit #(
    parameter int WIDTH = exe_pkg::DIV_STEPS
) (
    input  logic clk,
    input  logic reset,
    div_if.div   div
);
    import exe_pkg::*;

    logic [WIDTH-1:0] rem_q;
    logic [WIDTH-1:0] quot_q;      // dividend shifts out, quotient shifts in
    logic [WIDTH-1:0] divisor_q;
    logic [WIDTH-1:0] rem_in;
    logic [WIDTH-1:0] quot_in;
    logic [WIDTH-1:0] dvs;
    logic [WIDTH:0]   shifted;
    logic [WIDTH:0]   diff;
    logic             busy;

    // the start cycle works straight from the operands
    assign rem_in  = div.start ? '0 : rem_q;
    assign quot_in = div.start ? div.dividend[WIDTH-1:0] : quot_q;
    assign dvs     = div.start ? div.divisor[WIDTH-1:0] : divisor_q;

    assign shifted = {rem_in, quot_in[WIDTH-1]};
    assign diff    = shifted - {1'b0, dvs};   // msb set means borrow

    always_ff @(posedge clk) begin
        if (div.start)
            divisor_q <= div.divisor[WIDTH-1:0];
        if (div.start || busy) begin
            if (!diff[WIDTH]) begin
                rem_q  <= diff[WIDTH-1:0];
                quot_q <= {quot_in[WIDTH-2:0], 1'b1};
            end else begin
                rem_q  <= shifted[WIDTH-1:0];   // restore
                quot_q <= {quot_in[WIDTH-2:0], 1'b0};
            end
        end
    end

    div_iter_count #(
        .STEPS (WIDTH)
    ) u_count (
        .clk   (clk),
        .reset (reset),
        .start (div.start),
        .busy  (busy),
        .done  (div.done)
    );

    assign div.busy      = busy;
    assign div.quotient  = word_t'(quot_q);
    assign div.remainder = word_t'(rem_q);

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ns

module alu (
    input  exe_pkg::exe_op_t op,
    input  exe_pkg::word_t   src_a,
    input  exe_pkg::word_t   src_b,
    output exe_pkg::word_t   result,
    output logic             ovf
);
    import exe_pkg::*;

    word_t    sum;
    word_t    diff;
    logic     less;
    logic [4:0] shamt;

    assign sum   = src_a + src_b;   // also the memory address
    assign diff  = src_a - src_b;
    assign shamt = src_b[4:0];

    // signed compare from the subtraction sign and operand signs
    assign less = (src_a[31] != src_b[31]) ? src_a[31] : diff[31];

    always_comb begin
        case (op)
            op_add:  result = sum;
            op_sub:  result = diff;
            op_and:  result = src_a & src_b;
            op_or:   result = src_a | src_b;
            op_xor:  result = src_a ^ src_b;
            op_slt:  result = {31'd0, less};
            op_sll:  result = src_a << shamt;
            op_srl:  result = src_a >> shamt;
            op_lw, op_lh, op_lb,
            op_sw, op_sh, op_sb: result = sum;
            default: result = '0;   // divider ops take their result elsewhere
        endcase
    end

    // same-sign operands with a sign flip in the sum
    assign ovf = (op == op_add) && (src_a[31] == src_b[31]) && (sum[31] != src_a[31]);

endmodule

//--- rtl/store_align.sv
`timescale 1ns/1ns

module store_align (
    input  exe_pkg::exe_op_t op,
    input  exe_pkg::word_t   addr,
    input  exe_pkg::word_t   store_data,
    output logic             mem_wr,
    output exe_pkg::size_t   mem_size,
    output exe_pkg::strb_t   mem_wstrb,
    output exe_pkg::word_t   mem_wdata,
    output exe_pkg::exc_t    exc
);
    import exe_pkg::*;

    logic  is_load;
    logic  is_store;
    logic  misaligned;
    strb_t lanes;

    assign is_load  = (op == op_lw) || (op == op_lh) || (op == op_lb);
    assign is_store = (op == op_sw) || (op == op_sh) || (op == op_sb);

    always_comb begin
        case (op)
            op_lw, op_sw: mem_size = SIZE_WORD;
            op_lh, op_sh: mem_size = SIZE_HALF;
            default:      mem_size = SIZE_BYTE;
        endcase
    end

    always_comb begin
        misaligned = 1'b0;
        if (is_load || is_store) begin
            if (mem_size == SIZE_WORD)
                misaligned = (addr[1:0] != 2'b00);
            else if (mem_size == SIZE_HALF)
                misaligned = addr[0];
        end
    end

    assign exc = !misaligned ? exc_none :
                 is_store    ? exc_ades : exc_adel;

    // byte lanes touched by the access
    always_comb begin
        case (mem_size)
            SIZE_WORD: lanes = 4'b1111;
            SIZE_HALF: lanes = addr[1] ? 4'b1100 : 4'b0011;
            default:   lanes = 4'b0001 << addr[1:0];
        endcase
    end

    assign mem_wr    = is_store;
    assign mem_wstrb = is_store ? lanes : 4'b0000;   // loads write nothing

    // memory picks the lane, so data goes out on every lane
    assign mem_wdata = (mem_size == SIZE_WORD) ? store_data :
                       (mem_size == SIZE_HALF) ? {2{store_data[15:0]}} :
                                                 {4{store_data[7:0]}};

endmodule

//--- rtl/exe_ctrl.sv
`timescale 1ns/1ns

module exe_ctrl (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_allowin,
    input  exe_pkg::exe_op_t in_op,
    input  exe_pkg::word_t   in_src_a,
    input  exe_pkg::word_t   in_src_b,
    input  exe_pkg::word_t   in_store_data,
    input  exe_pkg::word_t   alu_result,
    input  logic             alu_ovf,
    input  exe_pkg::exc_t    addr_exc,
    output logic             out_valid,
    input  logic             out_allowin,
    output logic             mem_req,
    input  logic             mem_addr_ok,
    output exe_pkg::exe_op_t op_q,
    output exe_pkg::word_t   src_a_q,
    output exe_pkg::word_t   src_b_q,
    output exe_pkg::word_t   store_data_q,
    output exe_pkg::word_t   out_result,
    output exe_pkg::exc_t    out_exc,
    div_if.ctrl              div
);
    import exe_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t next_state;
    logic        accept;
    logic        finish;
    logic        start_q;
    logic        div_done_q;   // divider result sits in the stage

    always_comb begin
        case (in_op)
            op_divu, op_remu: next_state = st_div;
            op_lw, op_lh, op_lb, op_sw, op_sh, op_sb: next_state = st_mem;
            default: next_state = st_alu;
        endcase
    end

    // a faulting memory op never reaches the bus
    assign mem_req   = (state_q == st_mem) && (addr_exc == exc_none) && out_allowin;
    assign out_valid = (state_q == st_alu) || (state_q == st_mem)
                    || ((state_q == st_div) && div_done_q);

    // memory ops leave only once the address is taken
    always_comb begin
        case (state_q)
            st_alu:  finish = out_allowin;
            st_div:  finish = div_done_q && out_allowin;
            st_mem:  finish = (addr_exc != exc_none) ? out_allowin : (mem_req && mem_addr_ok);
            default: finish = 1'b0;
        endcase
    end

    assign in_allowin = (state_q == st_empty) || finish;   // back-to-back allowed
    assign accept     = in_valid && in_allowin;

    assign out_exc    = alu_ovf ? exc_ovf : addr_exc;
    assign out_result = (state_q != st_div) ? alu_result :
                        (op_q == op_remu)   ? div.remainder : div.quotient;

    assign div.start    = start_q;
    assign div.dividend = src_a_q;
    assign div.divisor  = src_b_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= st_empty;
            start_q    <= 1'b0;
            div_done_q <= 1'b0;
            op_q       <= op_add;   // decodes as a plain add while empty
        end else begin
            start_q <= accept && (next_state == st_div);
            if (accept) begin
                state_q <= next_state;
                op_q    <= in_op;
            end else if (finish) begin
                state_q <= st_empty;
            end
            if (accept)
                div_done_q <= 1'b0;
            else if (div.done)
                div_done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            src_a_q      <= in_src_a;
            src_b_q      <= in_src_b;
            store_data_q <= in_store_data;
        end
    end

endmodule

//--- rtl/exe_stage.sv
`timescale 1ns/1ns

module exe_stage #(
    parameter int DIV_WIDTH = exe_pkg::DIV_STEPS
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_allowin,
    input  exe_pkg::exe_op_t in_op,
    input  exe_pkg::word_t   in_src_a,
    input  exe_pkg::word_t   in_src_b,
    input  exe_pkg::word_t   in_store_data,
    output logic             out_valid,
    input  logic             out_allowin,
    output exe_pkg::word_t   out_result,
    output exe_pkg::exc_t    out_exc,
    output logic             mem_req,
    output logic             mem_wr,
    output exe_pkg::size_t   mem_size,
    output exe_pkg::strb_t   mem_wstrb,
    output exe_pkg::word_t   mem_addr,
    output exe_pkg::word_t   mem_wdata,
    input  logic             mem_addr_ok
);
    import exe_pkg::*;

    exe_op_t op_q;
    word_t   src_a_q;
    word_t   src_b_q;
    word_t   store_data_q;
    word_t   alu_result;
    logic    alu_ovf;
    exc_t    addr_exc;

    div_if div_bus ();

    exe_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_allowin    (in_allowin),
        .in_op         (in_op),
        .in_src_a      (in_src_a),
        .in_src_b      (in_src_b),
        .in_store_data (in_store_data),
        .alu_result    (alu_result),
        .alu_ovf       (alu_ovf),
        .addr_exc      (addr_exc),
        .out_valid     (out_valid),
        .out_allowin   (out_allowin),
        .mem_req       (mem_req),
        .mem_addr_ok   (mem_addr_ok),
        .op_q          (op_q),
        .src_a_q       (src_a_q),
        .src_b_q       (src_b_q),
        .store_data_q  (store_data_q),
        .out_result    (out_result),
        .out_exc       (out_exc),
        .div           (div_bus.ctrl)
    );

    div_unit #(
        .WIDTH (DIV_WIDTH)
    ) u_div (
        .clk   (clk),
        .reset (reset),
        .div   (div_bus.div)
    );

    alu u_alu (
        .op     (op_q),
        .src_a  (src_a_q),
        .src_b  (src_b_q),
        .result (alu_result),
        .ovf    (alu_ovf)
    );

    store_align u_align (
        .op         (op_q),
        .addr       (alu_result),   // address add happens in the ALU
        .store_data (store_data_q),
        .mem_wr     (mem_wr),
        .mem_size   (mem_size),
        .mem_wstrb  (mem_wstrb),
        .mem_wdata  (mem_wdata),
        .exc        (addr_exc)
    );

    assign mem_addr = alu_result;

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;   // released away from the sampling edge
    end

endmodule

//--- test/exe_stage_asserts.sv
`timescale 1ns/1ns

module exe_stage_asserts (
    input logic            clk,
    input logic            reset,
    input logic            out_valid,
    input logic            out_allowin,
    input exe_pkg::word_t  out_result,
    input exe_pkg::exc_t   out_exc,
    input logic            mem_req,
    input logic            div_start,
    input logic            div_busy
);
    import exe_pkg::*;

    int fail_count = 0;   // read by the testbench at the end

    // a stalled result stays put until the next stage takes it
    hold_until_taken: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin |=> out_valid && $stable(out_result) && $stable(out_exc))
        else begin
            $error("output dropped or changed while out_allowin was low");
            fail_count++;
        end

    no_req_on_exc: assert property (@(posedge clk) disable iff (reset)
        mem_req |-> out_exc == exc_none)
        else begin
            $error("memory request raised for an operation with an exception");
            fail_count++;
        end

    no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
        div_start |-> !div_busy)
        else begin
            $error("divider started while still busy");
            fail_count++;
        end

endmodule

//--- test/tb_exe_stage.sv
`timescale 1ns/1ns

module tb_exe_stage;
    import exe_pkg::*;

    localparam int N_ALU = 64;
    localparam int N_DIV = 24;
    localparam int N_MEM = 24;
    localparam int N_MIS = 16;
    localparam int N_MIX = 172;
    // worst case about 40 cycles per operation
    localparam int MAX_CYCLES = (N_ALU + N_DIV + N_MEM + N_MIS + N_MIX) * 40;

    typedef struct packed {
        logic  makes_req;   // memory op without exception
        word_t result;
        exc_t  exc;
        logic  wr;
        size_t size;
        strb_t strb;
        word_t wdata;
    } exp_t;

    logic clk, reset;
    logic in_valid, in_allowin, out_valid, out_allowin;
    exe_op_t in_op;
    word_t in_src_a, in_src_b, in_store_data, out_result;
    exc_t out_exc;
    logic mem_req, mem_wr, mem_addr_ok;
    size_t mem_size;
    strb_t mem_wstrb;
    word_t mem_addr, mem_wdata;

    exp_t exp_q[$];
    int   issued = 0;
    int   results = 0;
    int   checks = 0;
    int   errors = 0;
    int   cycles = 0;
    logic bp_on = 1'b0;

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(8)) u_clk (.clk(clk), .reset(reset));

    exe_stage #(.DIV_WIDTH(DIV_STEPS)) dut (.*);

    bind exe_ctrl exe_stage_asserts u_asserts (
        .clk(clk), .reset(reset), .out_valid(out_valid), .out_allowin(out_allowin),
        .out_result(out_result), .out_exc(out_exc), .mem_req(mem_req),
        .div_start(start_q), .div_busy(div.busy)
    );

    function automatic exp_t expect_op(exe_op_t op, word_t a, word_t b, word_t sd);
        exp_t   e;
        longint s;
        word_t  addr;
        logic   bad;
        e = '0;
        bad = 1'b0;
        addr = a + b;
        case (op)
            op_add: begin
                e.result = a + b;
                s = longint'($signed(a)) + longint'($signed(b));
                if (s > 64'sd2147483647 || s < -64'sd2147483648)
                    e.exc = exc_ovf;
            end
            op_sub:  e.result = a - b;
            op_and:  e.result = a & b;
            op_or:   e.result = a | b;
            op_xor:  e.result = a ^ b;
            op_slt:  e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sll:  e.result = a << b[4:0];
            op_srl:  e.result = a >> b[4:0];
            op_divu: e.result = (b == 0) ? 32'hffff_ffff : a / b;
            op_remu: e.result = (b == 0) ? a : a % b;
            default: begin
                e.result = addr;
                e.wr = (op == op_sw) || (op == op_sh) || (op == op_sb);
                if (op == op_lw || op == op_sw) begin
                    e.size = 2'd2;
                    bad = (addr[1:0] != 2'b00);
                    e.strb = 4'b1111;
                    e.wdata = sd;
                end else if (op == op_lh || op == op_sh) begin
                    e.size = 2'd1;
                    bad = addr[0];
                    e.strb = addr[1] ? 4'b1100 : 4'b0011;
                    e.wdata = {sd[15:0], sd[15:0]};
                end else begin
                    e.size = 2'd0;
                    e.strb = 4'b0001 << addr[1:0];
                    e.wdata = {4{sd[7:0]}};
                end
                if (!e.wr)
                    e.strb = 4'b0000;
                if (bad)
                    e.exc = e.wr ? exc_ades : exc_adel;
                else
                    e.makes_req = 1'b1;
            end
        endcase
        return e;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // compare every completed transfer against the head of the queue
    always @(posedge clk) begin
        exp_t head;
        logic idle;
        logic taken;
        if (!reset) begin
            idle  = (exp_q.size() == 0);   // nothing held in the stage
            taken = 1'b0;
            if (out_valid) begin
                assert (!idle) else begin
                    $display("out_valid high at %0t ns with no operation outstanding", $time);
                    errors++;
                end
            end
            if (out_valid && !idle) begin
                head = exp_q[0];
                check_val("mem_req", mem_req, head.makes_req && out_allowin);
                taken = head.makes_req ? (out_allowin && mem_addr_ok) : out_allowin;
                if (taken) begin
                    check_val("out_result", out_result, head.result);
                    check_val("out_exc", out_exc, head.exc);
                    if (head.makes_req) begin
                        check_val("mem_addr", mem_addr, head.result);
                        check_val("mem_wr", mem_wr, head.wr);
                        check_val("mem_size", mem_size, head.size);
                        check_val("mem_wstrb", mem_wstrb, head.strb);
                        if (head.wr)
                            check_val("mem_wdata", mem_wdata, head.wdata);
                    end
                    void'(exp_q.pop_front());
                    results++;
                end
            end else begin
                check_val("mem_req", mem_req, 1'b0);
            end
            // room only in an empty stage or behind one that leaves now
            check_val("in_allowin", in_allowin, idle || taken);
            if (in_valid && in_allowin)
                exp_q.push_back(expect_op(in_op, in_src_a, in_src_b, in_store_data));
        end
    end

    always @(negedge clk) begin
        out_allowin = bp_on ? ($urandom_range(3, 0) != 0) : 1'b1;
        mem_addr_ok = bp_on ? ($urandom_range(2, 0) != 0) : 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d results outstanding", cycles, exp_q.size());
            $display("Test failed");
            $finish;
        end
    end

    task automatic send(exe_op_t op, word_t a, word_t b, word_t sd);
        @(negedge clk);
        in_valid = 1'b1;
        in_op = op;
        in_src_a = a;
        in_src_b = b;
        in_store_data = sd;
        @(posedge clk);
        while (!in_allowin)
            @(posedge clk);
        issued++;
    endtask

    task automatic drain_and_report(string name, int n_ops, int err_before);
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);
        $display("%-10s %0d ops, %0d errors", name, n_ops, errors - err_before);
    endtask

    initial begin
        int      e0;
        int      off;
        word_t   r;
        exe_op_t op;
        exe_op_t mem_ops[6];
        mem_ops = '{op_lw, op_lh, op_lb, op_sw, op_sh, op_sb};
        void'($urandom(32'h4f38));
        in_valid = 1'b0;
        in_op = op_add;
        in_src_a = '0;
        in_src_b = '0;
        in_store_data = '0;
        out_allowin = 1'b1;
        mem_addr_ok = 1'b1;
        @(negedge clk);
        while (reset)
            @(negedge clk);

        e0 = errors;
        check_val("out_valid", out_valid, 1'b0);
        check_val("mem_req", mem_req, 1'b0);
        check_val("in_allowin", in_allowin, 1'b1);
        $display("%-10s %0d ops, %0d errors", "reset", 0, errors - e0);

        e0 = errors;
        for (int i = 0; i < N_ALU; i++) begin
            r = $urandom;
            if (i % 8 == 0)        // positive overflow
                send(op_add, 32'h4000_0000 | (r & 32'h3fff_ffff),
                     32'h4000_0000 | ($urandom & 32'h3fff_ffff), 0);
            else if (i % 8 == 4)   // negative overflow
                send(op_add, 32'h8000_0000 | (r & 32'h3fff_ffff),
                     32'h8000_0000 | ($urandom & 32'h3fff_ffff), 0);
            else
                send(exe_op_t'($urandom_range(7, 0)), r, $urandom, 0);
        end
        drain_and_report("alu", N_ALU, e0);

        e0 = errors;
        for (int i = 0; i < N_DIV; i++) begin
            op = (i % 2 == 0) ? op_divu : op_remu;
            r = (i % 6 < 2) ? 32'd0 : ((i % 3 == 1) ? ($urandom % 256) : $urandom);
            send(op, $urandom, r, 0);
        end
        drain_and_report("div", N_DIV, e0);

        e0 = errors;
        for (int i = 0; i < N_MEM; i++) begin
            op = mem_ops[i / 4];
            if (op == op_lw || op == op_sw)
                off = 0;
            else if (op == op_lh || op == op_sh)
                off = (i % 2) * 2;
            else
                off = i % 4;
            send(op, $urandom & 32'hffff_fff0, off, $urandom);
        end
        drain_and_report("aligned", N_MEM, e0);

        e0 = errors;
        for (int i = 0; i < N_MIS; i++) begin
            op = (i % 4 == 0) ? op_lw : (i % 4 == 1) ? op_sw : (i % 4 == 2) ? op_lh : op_sh;
            off = (op == op_lw || op == op_sw) ? 1 + (i / 4) % 3 : (((i / 4) % 2) ? 3 : 1);
            send(op, $urandom & 32'hffff_fff0, off, $urandom);
        end
        drain_and_report("misalign", N_MIS, e0);

        e0 = errors;
        bp_on = 1'b1;   // random stalls on both sides
        for (int i = 0; i < N_MIX; i++)
            send(exe_op_t'($urandom_range(15, 0)), $urandom, $urandom % 64, $urandom);
        drain_and_report("stall", N_MIX, e0);
        bp_on = 1'b0;

        errors += dut.u_ctrl.u_asserts.fail_count;
        assert (results == issued) else begin
            $display("%0d operations issued but %0d results delivered", issued, results);
            errors++;
        end
        $display("ops %0d, results %0d, checks %0d, errors %0d", issued, results, checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- exe_stage.f
rtl/exe_pkg.sv
rtl/exe_div_if.sv
rtl/div_iter_count.sv
rtl/div_unit.sv
rtl/alu.sv
rtl/store_align.sv
rtl/exe_ctrl.sv
rtl/exe_stage.sv
test/tb_clock_gen.sv
test/exe_stage_asserts.sv
test/tb_exe_stage.sv
